/* build.f */
+incdir+logic
logic/dspPkg.sv
logic/coreIf.sv
logic/btb.sv
logic/progSeq.sv
logic/instrQueue.sv
logic/execUnit.sv
logic/dspCore.sv
dv/tbDspCore.sv

/* dv/tbDspCore.sv */
`default_nettype none

`include "dsp_cfg.svh"

module tbDspCore;
  timeunit 1ns;
  timeprecision 1ps;
  import dspPkg::*;

  localparam int CycleLimit = 4000;
  localparam int HaltLimit = 400;

  logic                DSPCLK = 1'b0;
  logic                rstN = 1'b0;
  logic [`ADDR_W-1:0]  pmA;
  logic                pmRd;
  logic [`INSTR_W-1:0] pmData = '0;
  logic [`DATA_W-1:0]  dmData;
  logic                dmWr;
  logic                dmRdy = 1'b1;
  logic                halted;

  logic [`INSTR_W-1:0] progMem [2**`ADDR_W];
  logic [`DATA_W-1:0]  expStores [$];
  logic                stallOn = 1'b0;
  logic                holdPending = 1'b0;
  logic [`DATA_W-1:0]  heldData = '0;
  logic [31:0]         rnd;
  integer              seed = 51384;
  int                  cycleCnt = 0;

  dspCore DUT (
    .DSPCLK (DSPCLK),
    .rstN   (rstN),
    .pmA    (pmA),
    .pmRd   (pmRd),
    .pmData (pmData),
    .dmData (dmData),
    .dmWr   (dmWr),
    .dmRdy  (dmRdy),
    .halted (halted)
  );

  always #50 DSPCLK = ~DSPCLK;

  task automatic reportFailure(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      reportFailure("value mismatch");
    end
  endtask

  // Synchronous program memory answers one cycle after pmRd
  always @(posedge DSPCLK) begin
    if (pmRd) begin
      pmData <= progMem[pmA];
    end
    rnd = $random(seed);
    dmRdy <= stallOn ? rnd[0] : 1'b1;
  end

  // Each dmWr with dmRdy high ends one store
  always @(posedge DSPCLK) begin
    if (!rstN) begin
      holdPending = 1'b0;
    end else begin
      if (holdPending) begin
        checkEq("dmWr", 32'(dmWr), 32'd1);
        checkEq("dmData", 32'(dmData), 32'(heldData));
      end
      if (dmWr && dmRdy) begin
        if (expStores.size() == 0) begin
          reportFailure($sformatf("store of 0x%h is beyond the expected list", dmData));
        end else begin
          checkEq("dmData", 32'(dmData), 32'(expStores.pop_front()));
        end
      end
      holdPending = dmWr && !dmRdy;
      heldData = dmData;
    end
  end

  always @(posedge DSPCLK) begin
    cycleCnt++;
    if (cycleCnt >= CycleLimit) begin
      reportFailure("timeout: the tests ran past the cycle limit");
    end
  end

  function automatic logic [`INSTR_W-1:0] enc(input logic [3:0] op, input int dst,
                                              input int src, input int imm);
    return {op, dst[1:0], src[1:0], imm[15:0]};
  endfunction

  // Unused words decode as HALT with the address in the immediate
  task automatic clearMem();
    for (int a = 0; a < 2**`ADDR_W; a++) begin
      progMem[a] = {opHalt, 4'h0, 16'(a)};
    end
  endtask

  // Architectural interpreter of the loaded program
  task automatic buildExpected();
    logic [`DATA_W-1:0]  r [4];
    logic [`ADDR_W-1:0]  pc;
    logic [`INSTR_W-1:0] w;
    int                  steps;
    logic                done;
    for (int i = 0; i < 4; i++) begin
      r[i] = '0;
    end
    pc = '0;
    steps = 0;
    done = 1'b0;
    expStores.delete();
    while (!done) begin
      w = progMem[pc];
      pc = pc + 1'b1;
      case (w[23:20])
        opLdi:   r[w[19:18]] = w[15:0];
        opAdd:   r[w[19:18]] = r[w[19:18]] + r[w[17:16]];
        opSub:   r[w[19:18]] = r[w[19:18]] - r[w[17:16]];
        opStore: expStores.push_back(r[w[17:16]]);
        opJump:  pc = w[13:0];
        opJnz:   if (r[w[17:16]] != '0) pc = w[13:0];
        opHalt:  done = 1'b1;
        default: begin
        end
      endcase
      steps++;
      if (steps > 1000) begin
        reportFailure("reference model found no HALT in the program");
      end
    end
  endtask

  task automatic resetDut();
    int waitCnt;
    @(posedge DSPCLK);
    rstN <= 1'b0;
    repeat (5) begin
      @(posedge DSPCLK);
      checkEq("pmRd", 32'(pmRd), 32'd0);
      checkEq("dmWr", 32'(dmWr), 32'd0);
      checkEq("halted", 32'(halted), 32'd0);
    end
    buildExpected();
    rstN <= 1'b1;
    waitCnt = 0;
    do begin
      @(posedge DSPCLK);
      waitCnt++;
    end while (!pmRd && waitCnt < 10);
    if (!pmRd) begin
      reportFailure("no program fetch after reset release");
    end
    checkEq("pmA", 32'(pmA), 32'd0);
  endtask

  task automatic waitHalt();
    int waitCnt;
    waitCnt = 0;
    while (!halted && waitCnt < HaltLimit) begin
      @(posedge DSPCLK);
      waitCnt++;
    end
    if (!halted) begin
      reportFailure("program did not reach HALT in time");
    end
    if (expStores.size() != 0) begin
      reportFailure($sformatf("%0d expected stores never happened", expStores.size()));
    end
  endtask

  task automatic loadCountdown(input int start);
    clearMem();
    progMem[0] = enc(opLdi, 0, 0, start);
    progMem[1] = enc(opLdi, 1, 0, 1);
    progMem[2] = enc(opStore, 0, 0, 0);
    progMem[3] = enc(opSub, 0, 1, 0);
    progMem[4] = enc(opJnz, 0, 0, 2);
    progMem[5] = enc(opLdi, 2, 0, 'h00AA);
    progMem[6] = enc(opStore, 0, 2, 0);
    progMem[7] = enc(opHalt, 0, 0, 0);
  endtask

  task automatic straightLine();
    clearMem();
    progMem[0] = enc(opLdi, 0, 0, 5);
    progMem[1] = enc(opLdi, 1, 0, 'h1234);
    progMem[2] = enc(opAdd, 0, 1, 0);
    progMem[3] = enc(opStore, 0, 0, 0);
    progMem[4] = enc(opSub, 1, 0, 0);
    progMem[5] = enc(opStore, 0, 1, 0);
    progMem[6] = enc(opLdi, 2, 0, 'hFFFF);
    progMem[7] = enc(opLdi, 3, 0, 1);
    progMem[8] = enc(opAdd, 2, 3, 0);
    progMem[9] = enc(opStore, 0, 2, 0);
    progMem[10] = enc(opHalt, 0, 0, 0);
    resetDut();
    waitHalt();
  endtask

  task automatic countdownLoop();
    loadCountdown(5);
    resetDut();
    waitHalt();
  endtask

  task automatic skippedPaths();
    clearMem();
    progMem[0] = enc(opLdi, 0, 0, 7);
    progMem[1] = enc(opJump, 0, 0, 4);
    progMem[2] = enc(opStore, 0, 0, 0);
    progMem[3] = enc(opStore, 0, 0, 0);
    progMem[4] = enc(opLdi, 1, 0, 'h0011);
    progMem[5] = enc(opStore, 0, 1, 0);
    progMem[6] = enc(opLdi, 2, 0, 0);
    progMem[7] = enc(opJnz, 0, 2, 10);
    progMem[8] = enc(opStore, 0, 0, 0);
    progMem[9] = enc(opHalt, 0, 0, 0);
    progMem[10] = enc(opStore, 0, 1, 0);
    progMem[11] = enc(opHalt, 0, 0, 0);
    resetDut();
    waitHalt();
  endtask

  task automatic randomStalls();
    loadCountdown(9);
    stallOn <= 1'b1;
    resetDut();
    waitHalt();
    stallOn <= 1'b0;
  endtask

  task automatic resetMidRun();
    loadCountdown(12);
    resetDut();
    repeat (25) @(posedge DSPCLK);
    if (halted) begin
      reportFailure("program finished before the mid-run reset");
    end
    resetDut();
    waitHalt();
  endtask

  task automatic haltAndUnknown();
    clearMem();
    progMem[0] = enc(opLdi, 0, 0, 'h0055);
    progMem[1] = enc(opStore, 0, 0, 0);
    progMem[2] = enc(4'hC, 0, 0, 'h1111);
    progMem[3] = enc(4'h9, 0, 0, 'h2222);
    progMem[4] = enc(opStore, 0, 0, 0);
    progMem[5] = enc(opHalt, 0, 0, 0);
    progMem[6] = enc(opStore, 0, 0, 0);
    resetDut();
    waitHalt();
    repeat (20) begin
      @(posedge DSPCLK);
      checkEq("pmRd", 32'(pmRd), 32'd0);
      checkEq("dmWr", 32'(dmWr), 32'd0);
      checkEq("halted", 32'(halted), 32'd1);
    end
  endtask

  initial begin
    straightLine();
    countdownLoop();
    skippedPaths();
    randomStalls();
    resetMidRun();
    haltAndUnknown();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* logic/btb.sv */
`default_nettype none

`include "dsp_cfg.svh"

module btb (
  input  logic               DSPCLK,
  input  logic               rstN,
  input  logic [`ADDR_W-1:0] lookupPc,
  redirectIf.seq             redirect,
  output logic               hit,
  output logic [`ADDR_W-1:0] target
);

  localparam int IdxW = $clog2(`BTB_DEPTH);
  localparam int TagW = `ADDR_W - IdxW;

  logic [`BTB_DEPTH-1:0] entryValid;
  logic [TagW-1:0]       tagMem [`BTB_DEPTH];
  logic [`ADDR_W-1:0]    targetMem [`BTB_DEPTH];
  logic [IdxW-1:0]       rdIdx;
  logic [IdxW-1:0]       wrIdx;

  assign rdIdx = lookupPc[IdxW-1:0];
  assign wrIdx = redirect.updPc[IdxW-1:0];

  // The tag holds the full upper pc so two branches never alias
  assign hit    = entryValid[rdIdx] && (tagMem[rdIdx] == lookupPc[`ADDR_W-1:IdxW]);
  assign target = targetMem[rdIdx];

  // A not-taken resolution drops the entry
  always_ff @(posedge DSPCLK or negedge rstN) begin
    if (!rstN) begin
      entryValid <= '0;
    end else if (redirect.update) begin
      entryValid[wrIdx] <= redirect.updTaken;
    end
  end

  always_ff @(posedge DSPCLK) begin
    if (redirect.update && redirect.updTaken) begin
      tagMem[wrIdx]    <= redirect.updPc[`ADDR_W-1:IdxW];
      targetMem[wrIdx] <= redirect.updTarget;
    end
  end

  // Branch resolution in the execution unit stays quiet while the core is in reset
  noUpdateInReset: assert property (@(posedge DSPCLK) !rstN |-> !redirect.update);

endmodule

`default_nettype wire

/* logic/coreIf.sv */
`default_nettype none

`include "dsp_cfg.svh"

// Entry handoff between two stages
// On the fetch side valid is the one-cycle push strobe and pop acknowledges it
// On the issue side valid marks a head entry and pop takes it
interface fetchIf;
  import dspPkg::*;

  logic       valid;
  fetchEntryT entry;
  logic       pop;
  freeCntT    free;

  modport producer (
    output valid,
    output entry,
    input  pop,
    input  free
  );

  modport consumer (
    input  valid,
    input  entry,
    output pop,
    output free
  );
endinterface

// Branch resolution back to the sequencer and BTB
interface redirectIf;
  logic               flush;
  logic [`ADDR_W-1:0] newPc;
  logic               update;
  logic [`ADDR_W-1:0] updPc;
  logic               updTaken;
  logic [`ADDR_W-1:0] updTarget;

  modport exec (
    output flush,
    output newPc,
    output update,
    output updPc,
    output updTaken,
    output updTarget
  );

  modport seq (
    input flush,
    input newPc,
    input update,
    input updPc,
    input updTaken,
    input updTarget
  );
endinterface

`default_nettype wire

/* logic/dspCore.sv */
`default_nettype none

`include "dsp_cfg.svh"

module dspCore (
  input  logic                DSPCLK,
  input  logic                rstN,
  output logic [`ADDR_W-1:0]  pmA,
  output logic                pmRd,
  input  logic [`INSTR_W-1:0] pmData,
  output logic [`DATA_W-1:0]  dmData,
  output logic                dmWr,
  input  logic                dmRdy,
  output logic                halted
);

  fetchIf    fetchBus ();
  fetchIf    issueBus ();
  redirectIf redirectBus ();

  progSeq uProgSeq (
    .DSPCLK   (DSPCLK),
    .rstN     (rstN),
    .halted   (halted),
    .pmData   (pmData),
    .redirect (redirectBus),
    .pmA      (pmA),
    .pmRd     (pmRd),
    .fetch    (fetchBus)
  );

  // A misprediction drops everything still waiting in the queue
  instrQueue uInstrQueue (
    .DSPCLK (DSPCLK),
    .rstN   (rstN),
    .flush  (redirectBus.flush),
    .fetch  (fetchBus),
    .issue  (issueBus)
  );

  execUnit uExecUnit (
    .DSPCLK   (DSPCLK),
    .rstN     (rstN),
    .dmRdy    (dmRdy),
    .dmData   (dmData),
    .dmWr     (dmWr),
    .halted   (halted),
    .issue    (issueBus),
    .redirect (redirectBus)
  );

endmodule

`default_nettype wire

/* logic/dspPkg.sv */
`default_nettype none

`include "dsp_cfg.svh"

package dspPkg;

  // Anything outside this list executes as a NOP
  typedef enum logic [3:0] {
    opNop   = 4'h0,
    opLdi   = 4'h1,
    opAdd   = 4'h2,
    opSub   = 4'h3,
    opStore = 4'h4,
    opJump  = 4'h5,
    opJnz   = 4'h6,
    opHalt  = 4'h7
  } opcodeT;

  // Branch target sits in the low ADDR_W bits of imm
  typedef struct packed {
    opcodeT             opcode;
    logic [1:0]         dst;
    logic [1:0]         src;
    logic [`DATA_W-1:0] imm;
  } instrFieldsT;

  typedef struct packed {
    logic [`INSTR_W-1:0] instr;
    logic [`ADDR_W-1:0]  pc;
    logic                predTaken;
    logic [`ADDR_W-1:0]  predPc;
  } fetchEntryT;

  // Wide enough to count every queue slot including the full case
  typedef logic [$clog2(`IQ_DEPTH + 1)-1:0] freeCntT;

endpackage

`default_nettype wire

/* logic/dsp_cfg.svh */
`ifndef DSP_CFG_SVH
`define DSP_CFG_SVH

// Program address, register and instruction widths
`define ADDR_W 14
`define DATA_W 16
`define INSTR_W 24

// Branch target buffer entries
`define BTB_DEPTH 16

// Instruction queue entries
`define IQ_DEPTH 4

`endif

/* logic/execUnit.sv */
`default_nettype none

`include "dsp_cfg.svh"

module execUnit (
  input  logic               DSPCLK,
  input  logic               rstN,
  input  logic               dmRdy,
  output logic [`DATA_W-1:0] dmData,
  output logic               dmWr,
  output logic               halted,
  fetchIf.consumer           issue,
  redirectIf.exec            redirect
);
  import dspPkg::*;

  fetchEntryT         head;
  instrFieldsT        fields;
  logic [`DATA_W-1:0] regs [4];
  logic [`DATA_W-1:0] dstVal;
  logic [`DATA_W-1:0] srcVal;
  logic               isStore;
  logic               isBranch;
  logic               taken;
  logic               pop;
  logic [`ADDR_W-1:0] seqPc;
  logic [`ADDR_W-1:0] realNext;

  assign head   = issue.entry;
  assign fields = instrFieldsT'(head.instr);
  assign dstVal = regs[fields.dst];
  assign srcVal = regs[fields.src];

  assign isStore = issue.valid && !halted && (fields.opcode == opStore);

  // Registers cannot change while a store waits so dmData holds by itself
  assign dmWr   = isStore;
  assign dmData = srcVal;

  // Only a store waits on the data port
  assign pop        = issue.valid && !halted && (!isStore || dmRdy);
  assign issue.pop  = pop;

  always_comb begin
    isBranch = 1'b0;
    taken    = 1'b0;
    case (fields.opcode)
      opJump: begin
        isBranch = 1'b1;
        taken    = 1'b1;
      end
      opJnz: begin
        isBranch = 1'b1;
        taken    = (srcVal != '0);
      end
      default: begin
      end
    endcase
  end

  assign seqPc    = head.pc + 1'b1;
  assign realNext = taken ? fields.imm[`ADDR_W-1:0] : seqPc;

  // Every resolved branch trains the BTB
  assign redirect.update    = pop && isBranch;
  assign redirect.updPc     = head.pc;
  assign redirect.updTaken  = taken;
  assign redirect.updTarget = fields.imm[`ADDR_W-1:0];

  assign redirect.flush = pop && isBranch && (realNext != head.predPc);
  assign redirect.newPc = realNext;

  always_ff @(posedge DSPCLK or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 4; i++) begin
        regs[i] <= '0;
      end
      halted <= 1'b0;
    end else if (pop) begin
      case (fields.opcode)
        opLdi:   regs[fields.dst] <= fields.imm;
        opAdd:   regs[fields.dst] <= dstVal + srcVal;
        opSub:   regs[fields.dst] <= dstVal - srcVal;
        opHalt:  halted <= 1'b1;
        default: begin
        end
      endcase
    end
  end

  storeHeld: assert property (@(posedge DSPCLK) disable iff (!rstN)
    dmWr && !dmRdy |=> dmWr && $stable(dmData));

endmodule

`default_nettype wire

/* logic/instrQueue.sv */
`default_nettype none

`include "dsp_cfg.svh"

module instrQueue (
  input  logic      DSPCLK,
  input  logic      rstN,
  input  logic      flush,
  fetchIf.consumer  fetch,
  fetchIf.producer  issue
);
  import dspPkg::*;

  localparam int PtrW = $clog2(`IQ_DEPTH);
  localparam int LastSlot = `IQ_DEPTH - 1;

  fetchEntryT      mem [`IQ_DEPTH];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  freeCntT         count;
  logic            wrEn;
  logic            rdEn;

  assign wrEn = fetch.valid && (count != freeCntT'(`IQ_DEPTH));
  assign rdEn = issue.pop;

  assign fetch.pop  = wrEn;
  assign fetch.free = freeCntT'(`IQ_DEPTH) - count;

  assign issue.valid = (count != '0);
  assign issue.entry = mem[rdPtr];

  always_ff @(posedge DSPCLK or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else if (flush) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (wrEn) begin
        wrPtr <= (wrPtr == PtrW'(LastSlot)) ? '0 : wrPtr + 1'b1;
      end
      if (rdEn) begin
        rdPtr <= (rdPtr == PtrW'(LastSlot)) ? '0 : rdPtr + 1'b1;
      end
      case ({wrEn, rdEn})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge DSPCLK) begin
    if (wrEn) begin
      mem[wrPtr] <= fetch.entry;
    end
  end

  noPushWhenFull: assert property (@(posedge DSPCLK) disable iff (!rstN)
    fetch.valid |-> count != freeCntT'(`IQ_DEPTH));

  // The execution unit only takes the head while the queue holds one
  noPopWhenEmpty: assert property (@(posedge DSPCLK) disable iff (!rstN)
    issue.pop |-> count != '0);

endmodule

`default_nettype wire

/* logic/progSeq.sv */
`default_nettype none

`include "dsp_cfg.svh"

module progSeq (
  input  logic                DSPCLK,
  input  logic                rstN,
  input  logic                halted,
  input  logic [`INSTR_W-1:0] pmData,
  redirectIf.seq              redirect,
  output logic [`ADDR_W-1:0]  pmA,
  output logic                pmRd,
  fetchIf.producer            fetch
);
  import dspPkg::*;

  logic [`ADDR_W-1:0] pc;
  logic               pmRdQ;
  logic               inFlight;
  logic               reqPredTaken;
  logic [`ADDR_W-1:0] reqPredPc;
  logic [`ADDR_W-1:0] flightPc;
  logic               flightPredTaken;
  logic [`ADDR_W-1:0] flightPredPc;
  logic [`ADDR_W-1:0] lookupPc;
  logic               btbHit;
  logic [`ADDR_W-1:0] btbTarget;
  logic [`ADDR_W-1:0] predPc;
  freeCntT            outstanding;
  logic               issue;

  btb uBtb (
    .DSPCLK   (DSPCLK),
    .rstN     (rstN),
    .lookupPc (lookupPc),
    .redirect (redirect),
    .hit      (btbHit),
    .target   (btbTarget)
  );

  // A redirect restarts fetch at the resolved address in the next cycle
  assign lookupPc = redirect.flush ? redirect.newPc : pc;
  assign predPc   = btbHit ? btbTarget : lookupPc + 1'b1;

  // Words requested but not yet counted by the queue
  assign outstanding = freeCntT'(inFlight) + freeCntT'(pmRd);

  // The queue is cleared on a flush so credits are not needed then
  assign issue = !halted && (redirect.flush || (fetch.free > outstanding));

  // Nothing may be requested once the core has halted
  assign pmRd = pmRdQ && !halted;

  always_ff @(posedge DSPCLK or negedge rstN) begin
    if (!rstN) begin
      pc       <= '0;
      pmRdQ    <= 1'b0;
      inFlight <= 1'b0;
    end else begin
      pmRdQ    <= issue;
      inFlight <= pmRd && !redirect.flush;
      if (issue) begin
        pc <= predPc;
      end
    end
  end

  // The prediction follows its request down to the returning word
  always_ff @(posedge DSPCLK) begin
    if (issue) begin
      pmA          <= lookupPc;
      reqPredTaken <= btbHit;
      reqPredPc    <= predPc;
    end
    if (pmRd) begin
      flightPc        <= pmA;
      flightPredTaken <= reqPredTaken;
      flightPredPc    <= reqPredPc;
    end
  end

  // Word returning during a flush belongs to the wrong path
  assign fetch.valid = inFlight && !redirect.flush;
  assign fetch.entry = fetchEntryT'{
    instr:     pmData,
    pc:        flightPc,
    predTaken: flightPredTaken,
    predPc:    flightPredPc
  };

  pushWithCredit: assert property (@(posedge DSPCLK) disable iff (!rstN)
    fetch.valid |-> (fetch.free != '0) && fetch.pop);

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the DSP core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tbDspCore -f build.f -o simDspCore

./obj_dir/simDspCore
